// ==== src/axi_mux_pkg.sv ====
`default_nettype none

package axi_mux_pkg;

   localparam int ID_W   = 4;
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;
   localparam int LEN_W  = 8;
   localparam int SIZE_W = 3;
   localparam int RESP_W = 2;

   typedef enum logic [0:0] {
      PORT_A = 1'b0,
      PORT_B = 1'b1
   } axi_port_e;

   typedef enum logic [RESP_W-1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

endpackage

`default_nettype wire

// ==== src/axi_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axi_bus_if ();
   import axi_mux_pkg::*;

   // Write address.
   logic [ID_W-1:0]   awid;
   logic [ADDR_W-1:0] awaddr;
   logic [LEN_W-1:0]  awlen;
   logic [SIZE_W-1:0] awsize;
   logic              awvalid;
   logic              awready;

   // Write data, no wid.
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              wlast;
   logic              wvalid;
   logic              wready;

   // Read address.
   logic [ID_W-1:0]   arid;
   logic [ADDR_W-1:0] araddr;
   logic [LEN_W-1:0]  arlen;
   logic [SIZE_W-1:0] arsize;
   logic              arvalid;
   logic              arready;

   // Read data.
   logic [ID_W-1:0]   rid;
   logic [DATA_W-1:0] rdata;
   logic [RESP_W-1:0] rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;

   // Write response.
   logic [ID_W-1:0]   bid;
   logic [RESP_W-1:0] bresp;
   logic              bvalid;
   logic              bready;

   modport master (
      output awid, awaddr, awlen, awsize, awvalid, wdata, wstrb, wlast, wvalid,
      output arid, araddr, arlen, arsize, arvalid, rready, bready,
      input  awready, wready, arready, rid, rdata, rresp, rlast, rvalid, bid, bresp, bvalid
   );

   modport slave (
      input  awid, awaddr, awlen, awsize, awvalid, wdata, wstrb, wlast, wvalid,
      input  arid, araddr, arlen, arsize, arvalid, rready, bready,
      output awready, wready, arready, rid, rdata, rresp, rlast, rvalid, bid, bresp, bvalid
   );

endinterface

`default_nettype wire

// ==== src/register_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_slice #(
   parameter int WIDTH  = 8,
   parameter int STAGES = 1
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             s_valid,
   output logic             s_ready,
   input  logic [WIDTH-1:0] s_data,
   output logic             m_valid,
   input  logic             m_ready,
   output logic [WIDTH-1:0] m_data
);

   generate
      if (STAGES == 0) begin : g_wire
         assign m_valid = s_valid;
         assign m_data  = s_data;
         assign s_ready = m_ready;
      end else begin : g_chain
         // Index 0 is the input side, index STAGES the output.
         wire [STAGES:0]            valid;
         wire [STAGES:0]            ready;
         wire [STAGES:0][WIDTH-1:0] data;

         assign valid[0]      = s_valid;
         assign data[0]       = s_data;
         assign s_ready       = ready[0];
         assign ready[STAGES] = m_ready;
         assign m_valid       = valid[STAGES];
         assign m_data        = data[STAGES];

         for (genvar i = 0; i < STAGES; i++) begin : g_stage
            logic             valid_q;
            logic [WIDTH-1:0] data_q;

            // Load when empty or draining this cycle.
            assign ready[i] = !valid_q || ready[i+1];

            always_ff @(posedge clk) begin
               if (!rstn) begin
                  valid_q <= 1'b0;
               end else if (ready[i]) begin
                  valid_q <= valid[i];
               end
            end

            always_ff @(posedge clk) begin
               if (ready[i] && valid[i]) begin
                  data_q <= data[i];
               end
            end

            assign valid[i+1] = valid_q;
            assign data[i+1]  = data_q;
         end
      end
   endgenerate

endmodule

`default_nettype wire

// ==== src/axi_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_pipe #(
   parameter int STAGES  = 1,
   parameter int NO_RESP = 0
) (
   input logic       clk,
   input logic       rstn,
   axi_bus_if.slave  up,
   axi_bus_if.master down
);
   import axi_mux_pkg::*;

   localparam int ACH_W = ID_W + ADDR_W + LEN_W + SIZE_W;
   localparam int W_W   = DATA_W + STRB_W + 1;
   localparam int R_W   = ID_W + DATA_W + RESP_W + 1;
   localparam int B_W   = ID_W + RESP_W;
   // Responses go straight through when NO_RESP is set.
   localparam int RESP_STAGES = (NO_RESP != 0) ? 0 : STAGES;

   register_slice #(
      .WIDTH (ACH_W),
      .STAGES(STAGES)
   ) aw_slice (
      .clk    (clk),
      .rstn   (rstn),
      .s_valid(up.awvalid),
      .s_ready(up.awready),
      .s_data ({up.awid, up.awaddr, up.awlen, up.awsize}),
      .m_valid(down.awvalid),
      .m_ready(down.awready),
      .m_data ({down.awid, down.awaddr, down.awlen, down.awsize})
   );

   register_slice #(
      .WIDTH (W_W),
      .STAGES(STAGES)
   ) w_slice (
      .clk    (clk),
      .rstn   (rstn),
      .s_valid(up.wvalid),
      .s_ready(up.wready),
      .s_data ({up.wdata, up.wstrb, up.wlast}),
      .m_valid(down.wvalid),
      .m_ready(down.wready),
      .m_data ({down.wdata, down.wstrb, down.wlast})
   );

   register_slice #(
      .WIDTH (ACH_W),
      .STAGES(STAGES)
   ) ar_slice (
      .clk    (clk),
      .rstn   (rstn),
      .s_valid(up.arvalid),
      .s_ready(up.arready),
      .s_data ({up.arid, up.araddr, up.arlen, up.arsize}),
      .m_valid(down.arvalid),
      .m_ready(down.arready),
      .m_data ({down.arid, down.araddr, down.arlen, down.arsize})
   );

   // Response channels run from the slave side back up.
   register_slice #(
      .WIDTH (R_W),
      .STAGES(RESP_STAGES)
   ) r_slice (
      .clk    (clk),
      .rstn   (rstn),
      .s_valid(down.rvalid),
      .s_ready(down.rready),
      .s_data ({down.rid, down.rdata, down.rresp, down.rlast}),
      .m_valid(up.rvalid),
      .m_ready(up.rready),
      .m_data ({up.rid, up.rdata, up.rresp, up.rlast})
   );

   register_slice #(
      .WIDTH (B_W),
      .STAGES(RESP_STAGES)
   ) b_slice (
      .clk    (clk),
      .rstn   (rstn),
      .s_valid(down.bvalid),
      .s_ready(down.bready),
      .s_data ({down.bid, down.bresp}),
      .m_valid(up.bvalid),
      .m_ready(up.bready),
      .m_data ({up.bid, up.bresp})
   );

endmodule

`default_nettype wire

// ==== src/axi_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mux #(
   parameter int ID_BIT  = axi_mux_pkg::ID_W - 1,
   parameter int DELAY   = 1,
   parameter int NO_RESP = 0
) (
   input logic       clk,
   input logic       rstn,
   axi_bus_if.slave  a,
   axi_bus_if.slave  b,
   axi_bus_if.master out_q
);
   import axi_mux_pkg::*;

   axi_bus_if bus_arb ();

   axi_port_e last_aw_q;
   axi_port_e last_ar_q;
   axi_port_e aw_cur_q;
   axi_port_e ar_cur_q;
   logic      aw_hold_q;
   logic      ar_hold_q;
   axi_port_e aw_sel;
   axi_port_e ar_sel;
   logic      lock_q;
   axi_port_e lock_port_q;
   logic      aw_fire;
   logic      ar_fire;
   logic      wlast_fire;
   logic      aw_is_b;
   logic      ar_is_b;
   logic      w_is_b;
   logic      r_is_b;
   logic      bid_is_b;

   // Round robin, the other port wins a tie.
   function automatic axi_port_e pick(axi_port_e last, logic va, logic vb);
      axi_port_e sel;
      if (va && vb) begin
         sel = (last == PORT_A) ? PORT_B : PORT_A;
      end else if (vb) begin
         sel = PORT_B;
      end else begin
         sel = PORT_A;
      end
      return sel;
   endfunction

   // A stalled request keeps its port until taken.
   assign aw_sel = aw_hold_q ? aw_cur_q : pick(last_aw_q, a.awvalid, b.awvalid);
   assign ar_sel = ar_hold_q ? ar_cur_q : pick(last_ar_q, a.arvalid, b.arvalid);

   assign aw_fire    = bus_arb.awvalid && bus_arb.awready;
   assign ar_fire    = bus_arb.arvalid && bus_arb.arready;
   assign wlast_fire = bus_arb.wvalid && bus_arb.wready && bus_arb.wlast;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_aw_q <= PORT_A;
         last_ar_q <= PORT_A;
         aw_cur_q  <= PORT_A;
         ar_cur_q  <= PORT_A;
         aw_hold_q <= 1'b0;
         ar_hold_q <= 1'b0;
      end else begin
         aw_cur_q  <= aw_sel;
         ar_cur_q  <= ar_sel;
         aw_hold_q <= bus_arb.awvalid && !bus_arb.awready;
         ar_hold_q <= bus_arb.arvalid && !bus_arb.arready;
         if (aw_fire) begin
            last_aw_q <= aw_sel;
         end
         if (ar_fire) begin
            last_ar_q <= ar_sel;
         end
      end
   end

   // W follows the AW winner up to its wlast beat.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         lock_q      <= 1'b0;
         lock_port_q <= PORT_A;
      end else if (wlast_fire) begin
         lock_q <= 1'b0;
      end else if (aw_fire) begin
         lock_q      <= 1'b1;
         lock_port_q <= aw_sel;
      end
   end

   assign aw_is_b = (aw_sel == PORT_B);
   assign ar_is_b = (ar_sel == PORT_B);
   assign w_is_b  = (lock_port_q == PORT_B);

   assign bus_arb.awid    = aw_is_b ? b.awid : a.awid;
   assign bus_arb.awaddr  = aw_is_b ? b.awaddr : a.awaddr;
   assign bus_arb.awlen   = aw_is_b ? b.awlen : a.awlen;
   assign bus_arb.awsize  = aw_is_b ? b.awsize : a.awsize;
   assign bus_arb.awvalid = (aw_is_b ? b.awvalid : a.awvalid) && !lock_q;
   assign a.awready       = bus_arb.awready && !lock_q && !aw_is_b;
   assign b.awready       = bus_arb.awready && !lock_q && aw_is_b;

   assign bus_arb.wdata  = w_is_b ? b.wdata : a.wdata;
   assign bus_arb.wstrb  = w_is_b ? b.wstrb : a.wstrb;
   assign bus_arb.wlast  = w_is_b ? b.wlast : a.wlast;
   assign bus_arb.wvalid = (w_is_b ? b.wvalid : a.wvalid) && lock_q;
   assign a.wready       = bus_arb.wready && lock_q && !w_is_b;
   assign b.wready       = bus_arb.wready && lock_q && w_is_b;

   assign bus_arb.arid    = ar_is_b ? b.arid : a.arid;
   assign bus_arb.araddr  = ar_is_b ? b.araddr : a.araddr;
   assign bus_arb.arlen   = ar_is_b ? b.arlen : a.arlen;
   assign bus_arb.arsize  = ar_is_b ? b.arsize : a.arsize;
   assign bus_arb.arvalid = ar_is_b ? b.arvalid : a.arvalid;
   assign a.arready       = bus_arb.arready && !ar_is_b;
   assign b.arready       = bus_arb.arready && ar_is_b;

   // Responses are routed by one ID bit.
   assign r_is_b   = bus_arb.rid[ID_BIT];
   assign bid_is_b = bus_arb.bid[ID_BIT];

   assign a.rvalid       = bus_arb.rvalid && !r_is_b;
   assign b.rvalid       = bus_arb.rvalid && r_is_b;
   assign bus_arb.rready = r_is_b ? b.rready : a.rready;
   assign a.bvalid       = bus_arb.bvalid && !bid_is_b;
   assign b.bvalid       = bus_arb.bvalid && bid_is_b;
   assign bus_arb.bready = bid_is_b ? b.bready : a.bready;

   assign a.rid   = bus_arb.rid;
   assign a.rdata = bus_arb.rdata;
   assign a.rresp = bus_arb.rresp;
   assign a.rlast = bus_arb.rlast;
   assign b.rid   = bus_arb.rid;
   assign b.rdata = bus_arb.rdata;
   assign b.rresp = bus_arb.rresp;
   assign b.rlast = bus_arb.rlast;
   assign a.bid   = bus_arb.bid;
   assign a.bresp = bus_arb.bresp;
   assign b.bid   = bus_arb.bid;
   assign b.bresp = bus_arb.bresp;

   axi_pipe #(
      .STAGES (DELAY),
      .NO_RESP(NO_RESP)
   ) u_pipe (
      .clk (clk),
      .rstn(rstn),
      .up  (bus_arb),
      .down(out_q)
   );

endmodule

`default_nettype wire

// ==== src/axi_mux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mux_top #(
   parameter int DELAY   = 1,
   parameter int NO_RESP = 0,
   parameter int ID_BIT  = axi_mux_pkg::ID_W - 1
) (
   input  logic                           clk,
   input  logic                           rstn,
   // Master A.
   input  logic [axi_mux_pkg::ID_W-1:0]   a_awid, a_arid,
   input  logic [axi_mux_pkg::ADDR_W-1:0] a_awaddr, a_araddr,
   input  logic [axi_mux_pkg::LEN_W-1:0]  a_awlen, a_arlen,
   input  logic [axi_mux_pkg::SIZE_W-1:0] a_awsize, a_arsize,
   input  logic [axi_mux_pkg::DATA_W-1:0] a_wdata,
   input  logic [axi_mux_pkg::STRB_W-1:0] a_wstrb,
   input  logic                           a_awvalid, a_wvalid, a_wlast, a_arvalid,
   input  logic                           a_rready, a_bready,
   output logic                           a_awready, a_wready, a_arready,
   output logic [axi_mux_pkg::ID_W-1:0]   a_rid, a_bid,
   output logic [axi_mux_pkg::DATA_W-1:0] a_rdata,
   output logic [axi_mux_pkg::RESP_W-1:0] a_rresp, a_bresp,
   output logic                           a_rlast, a_rvalid, a_bvalid,
   // Master B.
   input  logic [axi_mux_pkg::ID_W-1:0]   b_awid, b_arid,
   input  logic [axi_mux_pkg::ADDR_W-1:0] b_awaddr, b_araddr,
   input  logic [axi_mux_pkg::LEN_W-1:0]  b_awlen, b_arlen,
   input  logic [axi_mux_pkg::SIZE_W-1:0] b_awsize, b_arsize,
   input  logic [axi_mux_pkg::DATA_W-1:0] b_wdata,
   input  logic [axi_mux_pkg::STRB_W-1:0] b_wstrb,
   input  logic                           b_awvalid, b_wvalid, b_wlast, b_arvalid,
   input  logic                           b_rready, b_bready,
   output logic                           b_awready, b_wready, b_arready,
   output logic [axi_mux_pkg::ID_W-1:0]   b_rid, b_bid,
   output logic [axi_mux_pkg::DATA_W-1:0] b_rdata,
   output logic [axi_mux_pkg::RESP_W-1:0] b_rresp, b_bresp,
   output logic                           b_rlast, b_rvalid, b_bvalid,
   // Slave.
   output logic [axi_mux_pkg::ID_W-1:0]   s_awid, s_arid,
   output logic [axi_mux_pkg::ADDR_W-1:0] s_awaddr, s_araddr,
   output logic [axi_mux_pkg::LEN_W-1:0]  s_awlen, s_arlen,
   output logic [axi_mux_pkg::SIZE_W-1:0] s_awsize, s_arsize,
   output logic [axi_mux_pkg::DATA_W-1:0] s_wdata,
   output logic [axi_mux_pkg::STRB_W-1:0] s_wstrb,
   output logic                           s_awvalid, s_wvalid, s_wlast, s_arvalid,
   output logic                           s_rready, s_bready,
   input  logic                           s_awready, s_wready, s_arready,
   input  logic [axi_mux_pkg::ID_W-1:0]   s_rid, s_bid,
   input  logic [axi_mux_pkg::DATA_W-1:0] s_rdata,
   input  logic [axi_mux_pkg::RESP_W-1:0] s_rresp, s_bresp,
   input  logic                           s_rlast, s_rvalid, s_bvalid
);

   axi_bus_if bus_a ();
   axi_bus_if bus_b ();
   axi_bus_if bus_s ();

   // Master A requests in, responses out.
   assign {bus_a.awid, bus_a.awaddr, bus_a.awlen, bus_a.awsize, bus_a.awvalid} =
          {a_awid, a_awaddr, a_awlen, a_awsize, a_awvalid};
   assign {bus_a.wdata, bus_a.wstrb, bus_a.wlast, bus_a.wvalid} =
          {a_wdata, a_wstrb, a_wlast, a_wvalid};
   assign {bus_a.arid, bus_a.araddr, bus_a.arlen, bus_a.arsize, bus_a.arvalid} =
          {a_arid, a_araddr, a_arlen, a_arsize, a_arvalid};
   assign {bus_a.rready, bus_a.bready} = {a_rready, a_bready};
   assign {a_awready, a_wready, a_arready} = {bus_a.awready, bus_a.wready, bus_a.arready};
   assign {a_rid, a_rdata, a_rresp, a_rlast, a_rvalid} =
          {bus_a.rid, bus_a.rdata, bus_a.rresp, bus_a.rlast, bus_a.rvalid};
   assign {a_bid, a_bresp, a_bvalid} = {bus_a.bid, bus_a.bresp, bus_a.bvalid};

   // Master B.
   assign {bus_b.awid, bus_b.awaddr, bus_b.awlen, bus_b.awsize, bus_b.awvalid} =
          {b_awid, b_awaddr, b_awlen, b_awsize, b_awvalid};
   assign {bus_b.wdata, bus_b.wstrb, bus_b.wlast, bus_b.wvalid} =
          {b_wdata, b_wstrb, b_wlast, b_wvalid};
   assign {bus_b.arid, bus_b.araddr, bus_b.arlen, bus_b.arsize, bus_b.arvalid} =
          {b_arid, b_araddr, b_arlen, b_arsize, b_arvalid};
   assign {bus_b.rready, bus_b.bready} = {b_rready, b_bready};
   assign {b_awready, b_wready, b_arready} = {bus_b.awready, bus_b.wready, bus_b.arready};
   assign {b_rid, b_rdata, b_rresp, b_rlast, b_rvalid} =
          {bus_b.rid, bus_b.rdata, bus_b.rresp, bus_b.rlast, bus_b.rvalid};
   assign {b_bid, b_bresp, b_bvalid} = {bus_b.bid, bus_b.bresp, bus_b.bvalid};

   // Slave side, requests out and responses in.
   assign {s_awid, s_awaddr, s_awlen, s_awsize, s_awvalid} =
          {bus_s.awid, bus_s.awaddr, bus_s.awlen, bus_s.awsize, bus_s.awvalid};
   assign {s_wdata, s_wstrb, s_wlast, s_wvalid} =
          {bus_s.wdata, bus_s.wstrb, bus_s.wlast, bus_s.wvalid};
   assign {s_arid, s_araddr, s_arlen, s_arsize, s_arvalid} =
          {bus_s.arid, bus_s.araddr, bus_s.arlen, bus_s.arsize, bus_s.arvalid};
   assign {s_rready, s_bready} = {bus_s.rready, bus_s.bready};
   assign {bus_s.awready, bus_s.wready, bus_s.arready} = {s_awready, s_wready, s_arready};
   assign {bus_s.rid, bus_s.rdata, bus_s.rresp, bus_s.rlast, bus_s.rvalid} =
          {s_rid, s_rdata, s_rresp, s_rlast, s_rvalid};
   assign {bus_s.bid, bus_s.bresp, bus_s.bvalid} = {s_bid, s_bresp, s_bvalid};

   axi_mux #(
      .ID_BIT (ID_BIT),
      .DELAY  (DELAY),
      .NO_RESP(NO_RESP)
   ) u_mux (
      .clk  (clk),
      .rstn (rstn),
      .a    (bus_a),
      .b    (bus_b),
      .out_q(bus_s)
   );

endmodule

`default_nettype wire

// ==== test/axi_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mux_tb;
   import axi_mux_pkg::*;

   localparam int DELAY = 2;
   localparam int N_TXN = 40;
   localparam int N_RR  = 6;
   localparam int REQ_W = ID_W + ADDR_W + LEN_W + SIZE_W;
   localparam int Q_W   = ID_W + ADDR_W + LEN_W;
   localparam logic [ADDR_W-1:0] ADDR_LIMIT = 32'h0000_01ff;
   localparam longint LIMIT_NS = 200 * (2 * (N_TXN + N_RR)) * (DELAY + 1) * 20;

   logic clk;
   logic rstn;
   integer seed = 32'h2bd992d6;
   int errors = 0;
   int checks = 0;

   // Index 0 is master A and index 1 is master B.
   logic [1:0][ID_W-1:0]   awid, arid;
   logic [1:0][ADDR_W-1:0] awaddr, araddr;
   logic [1:0][LEN_W-1:0]  awlen, arlen;
   logic [1:0][SIZE_W-1:0] awsize, arsize;
   logic [1:0][DATA_W-1:0] wdata;
   logic [1:0][STRB_W-1:0] wstrb;
   logic [1:0] awvalid, wvalid, wlast, arvalid, rready, bready;
   wire  [1:0] awready, wready, arready, rlast, rvalid, bvalid;
   wire  [1:0][ID_W-1:0]   rid, bid;
   wire  [1:0][DATA_W-1:0] rdata;
   wire  [1:0][RESP_W-1:0] rresp, bresp;

   // Slave side.
   wire  [ID_W-1:0]   s_awid, s_arid;
   wire  [ADDR_W-1:0] s_awaddr, s_araddr;
   wire  [LEN_W-1:0]  s_awlen, s_arlen;
   wire  [SIZE_W-1:0] s_awsize, s_arsize;
   wire  [DATA_W-1:0] s_wdata;
   wire  [STRB_W-1:0] s_wstrb;
   wire               s_awvalid, s_wvalid, s_wlast, s_arvalid, s_rready, s_bready;
   logic              s_awready, s_wready, s_arready, s_rlast, s_rvalid, s_bvalid;
   logic [ID_W-1:0]   s_rid, s_bid;
   logic [DATA_W-1:0] s_rdata;
   logic [RESP_W-1:0] s_rresp, s_bresp;

   // Reference state.
   logic [1:0][REQ_W-1:0] aw_exp, ar_exp;
   logic [1:0] aw_pend, ar_pend, r_wait, b_wait;
   logic [DATA_W+STRB_W-1:0] w_exp [int];
   logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
   logic [DATA_W-1:0] slv_mem [logic [ADDR_W-1:0]];
   logic [Q_W-1:0] saw_q[$], sar_q[$];
   logic [ID_W-1:0] sb_q[$];
   int wr_issued [2], rd_issued [2], b_recv [2], r_recv [2];
   int sl_aw = 0, sl_wb = 0, sl_ar = 0, sl_b = 0, rr_checks = 0;

   axi_mux_top #(
      .DELAY  (DELAY),
      .NO_RESP(0),
      .ID_BIT (3)
   ) u_axi_mux_top (
      .a_awid(awid[0]), .a_awaddr(awaddr[0]), .a_awlen(awlen[0]), .a_awsize(awsize[0]),
      .a_awvalid(awvalid[0]), .a_awready(awready[0]), .a_wdata(wdata[0]),
      .a_wstrb(wstrb[0]), .a_wlast(wlast[0]), .a_wvalid(wvalid[0]), .a_wready(wready[0]),
      .a_arid(arid[0]), .a_araddr(araddr[0]), .a_arlen(arlen[0]), .a_arsize(arsize[0]),
      .a_arvalid(arvalid[0]), .a_arready(arready[0]), .a_rid(rid[0]), .a_rdata(rdata[0]),
      .a_rresp(rresp[0]), .a_rlast(rlast[0]), .a_rvalid(rvalid[0]), .a_rready(rready[0]),
      .a_bid(bid[0]), .a_bresp(bresp[0]), .a_bvalid(bvalid[0]), .a_bready(bready[0]),
      .b_awid(awid[1]), .b_awaddr(awaddr[1]), .b_awlen(awlen[1]), .b_awsize(awsize[1]),
      .b_awvalid(awvalid[1]), .b_awready(awready[1]), .b_wdata(wdata[1]),
      .b_wstrb(wstrb[1]), .b_wlast(wlast[1]), .b_wvalid(wvalid[1]), .b_wready(wready[1]),
      .b_arid(arid[1]), .b_araddr(araddr[1]), .b_arlen(arlen[1]), .b_arsize(arsize[1]),
      .b_arvalid(arvalid[1]), .b_arready(arready[1]), .b_rid(rid[1]), .b_rdata(rdata[1]),
      .b_rresp(rresp[1]), .b_rlast(rlast[1]), .b_rvalid(rvalid[1]), .b_rready(rready[1]),
      .b_bid(bid[1]), .b_bresp(bresp[1]), .b_bvalid(bvalid[1]), .b_bready(bready[1]),
      .*
   );

   always #10 clk = ~clk;

   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
      return {addr ^ 32'h5a5a_0f0f, ~addr};
   endfunction

   function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
                                                input logic [DATA_W-1:0] d,
                                                input logic [STRB_W-1:0] s);
      logic [DATA_W-1:0] r;
      r = old;
      for (int i = 0; i < STRB_W; i++) begin
         if (s[i]) begin
            r[8*i +: 8] = d[8*i +: 8];
         end
      end
      return r;
   endfunction

   task automatic check_aw(input string ch, input logic [ID_W-1:0] id,
                           input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                           input logic [SIZE_W-1:0] size, input logic [REQ_W-1:0] exp);
      checks++;
      if ({id, addr, len, size} !== exp) begin
         errors++;
         $display("[FAIL] %0t: %s id=%h addr=%h len=%0d size=%0d, expected %h",
                  $time, ch, id, addr, len, size, exp);
      end
   endtask

   task automatic check_w(input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s,
                          input logic last, input logic [DATA_W+STRB_W-1:0] exp,
                          input logic exp_last);
      checks++;
      if ({d, s} !== exp || last !== exp_last) begin
         errors++;
         $display("[FAIL] %0t: W data=%h strb=%h last=%b, expected %h last=%b",
                  $time, d, s, last, exp, exp_last);
      end
   endtask

   task automatic check_r(input logic [ID_W-1:0] id, input logic [DATA_W-1:0] d,
                          input axi_resp_e resp, input logic last,
                          input logic [ID_W-1:0] e_id, input logic [DATA_W-1:0] e_d,
                          input axi_resp_e e_resp, input logic e_last);
      checks++;
      if (id !== e_id || d !== e_d || resp !== e_resp || last !== e_last) begin
         errors++;
         $display("[FAIL] %0t: R id=%h data=%h resp=%s last=%b, expected %h %h %s %b",
                  $time, id, d, resp.name(), last, e_id, e_d, e_resp.name(), e_last);
      end
   endtask

   task automatic check_b(input logic [ID_W-1:0] id, input axi_resp_e resp,
                          input logic [ID_W-1:0] e_id, input axi_resp_e e_resp);
      checks++;
      if (id !== e_id || resp !== e_resp) begin
         errors++;
         $display("[FAIL] %0t: B id=%h resp=%s, expected %h %s",
                  $time, id, resp.name(), e_id, e_resp.name());
      end
   endtask

   task automatic do_write(input int m);
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] d;
      logic [STRB_W-1:0] s;
      int rnd;
      rnd = $random(seed) & 32'h7fffffff;
      addr = m * 256 + (rnd % 28) * 8;
      len = (rnd >> 8) % 4;
      id = {m[0], rnd[18:16]};
      {awid[m], awaddr[m], awlen[m], awsize[m], awvalid[m]} = {id, addr, len, 3'd3, 1'b1};
      aw_exp[m] = {id, addr, len, 3'd3};
      do @(posedge clk); while (!awready[m]);
      aw_pend[m] = 1'b1;
      wr_issued[m]++;
      #1 awvalid[m] = 1'b0;
      for (int i = 0; i <= len; i++) begin
         d = {$random(seed), $random(seed)};
         s = $random(seed);
         {wdata[m], wstrb[m], wlast[m], wvalid[m]} = {d, s, i == len, 1'b1};
         w_exp[m*4 + i] = {d, s};
         do @(posedge clk); while (!wready[m]);
         #1;
         ref_mem[addr + 8*i] = merge(ref_mem.exists(addr + 8*i) ? ref_mem[addr + 8*i] :
                                     fill_word(addr + 8*i), d, s);
      end
      wvalid[m] = 1'b0;
      b_wait[m] = 1'b1;
      do @(posedge clk); while (!(bvalid[m] && bready[m]));
      check_b(bid[m], axi_resp_e'(bresp[m]), id, OKAY);
      b_recv[m]++;
      #1 b_wait[m] = 1'b0;
   endtask

   task automatic do_read(input int m, input logic far);
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] a;
      logic [LEN_W-1:0]  len;
      logic [ID_W-1:0]   id;
      int rnd;
      rnd = $random(seed) & 32'h7fffffff;
      addr = (far ? 32'h400 : 32'h0) + m * 256 + (rnd % 28) * 8;
      len = (rnd >> 8) % 4;
      id = {m[0], rnd[18:16]};
      {arid[m], araddr[m], arlen[m], arsize[m], arvalid[m]} = {id, addr, len, 3'd3, 1'b1};
      ar_exp[m] = {id, addr, len, 3'd3};
      do @(posedge clk); while (!arready[m]);
      ar_pend[m] = 1'b1;
      rd_issued[m]++;
      #1 arvalid[m] = 1'b0;
      r_wait[m] = 1'b1;
      for (int i = 0; i <= len; i++) begin
         a = addr + 8*i;
         do @(posedge clk); while (!(rvalid[m] && rready[m]));
         if (a > ADDR_LIMIT) begin
            check_r(rid[m], rdata[m], axi_resp_e'(rresp[m]), rlast[m], id, '0, DECERR,
                    i == len);
         end else begin
            check_r(rid[m], rdata[m], axi_resp_e'(rresp[m]), rlast[m], id,
                    ref_mem.exists(a) ? ref_mem[a] : fill_word(a), OKAY, i == len);
         end
      end
      r_recv[m]++;
      #1 r_wait[m] = 1'b0;
   endtask

   task automatic run_master(input int m, input int n, input int gap_max, input logic rd_only);
      int g;
      for (int k = 0; k < n; k++) begin
         g = ($random(seed) & 32'h7fffffff) % (gap_max + 1);
         repeat (g) begin
            @(posedge clk);
            #1;
         end
         if (rd_only || $random(seed) % 2 == 0) begin
            do_read(m, ($random(seed) & 7) == 0);
         end else begin
            do_write(m);
         end
      end
   endtask

   // Response ready from the masters changes every cycle.
   always @(posedge clk) begin : master_ready
      int rnd;
      #1;
      rnd = $random(seed);
      rready = rnd[1:0];
      bready = rnd[3:2];
   end

   // Responses must only reach a master that waits for one.
   always @(posedge clk) begin
      if (rstn) begin
         for (int m = 0; m < 2; m++) begin
            if ((rvalid[m] && rready[m] && !r_wait[m]) ||
                (bvalid[m] && bready[m] && !b_wait[m])) begin
               errors++;
               $display("Response delivered to master %0d with nothing outstanding at %0t",
                        m, $time);
            end
         end
      end
   end

   // AR round robin is decided when no request is stalled.
   always @(posedge clk) begin : ar_rr
      logic      pend;
      logic      fresh_both;
      axi_port_e last;
      axi_port_e exp_sel;
      axi_port_e g;
      if (!rstn) begin
         pend = 1'b0;
         fresh_both = 1'b0;
         last = PORT_A;
         exp_sel = PORT_B;
      end else begin
         if (!pend) begin
            fresh_both = arvalid[0] && arvalid[1];
            exp_sel = (last == PORT_A) ? PORT_B : PORT_A;
         end
         if ((arvalid[0] && arready[0]) || (arvalid[1] && arready[1])) begin
            g = (arvalid[1] && arready[1]) ? PORT_B : PORT_A;
            if (fresh_both) begin
               rr_checks++;
               checks++;
               if (g != exp_sel) begin
                  errors++;
                  $display("[FAIL] %0t: AR grant to %s, expected %s", $time, g.name(),
                           exp_sel.name());
               end
            end
            last = g;
            pend = 1'b0;
         end else begin
            pend = arvalid[0] || arvalid[1];
         end
      end
   end

   // Slave model with a sparse memory.
   always begin : slave_model
      logic [Q_W-1:0]    h;
      logic [ADDR_W-1:0] a;
      int wbeat;
      int rbeat;
      int rnd;
      @(posedge clk);
      if (!rstn) begin
         saw_q.delete();
         sar_q.delete();
         sb_q.delete();
         wbeat = 0;
         rbeat = 0;
      end else begin
         if (s_awvalid && s_awready) begin
            if (!aw_pend[s_awid[3]]) begin
               errors++;
               $display("AW at the slave port with no matching master request at %0t", $time);
            end
            check_aw("AW", s_awid, s_awaddr, s_awlen, s_awsize, aw_exp[s_awid[3]]);
            aw_pend[s_awid[3]] = 1'b0;
            saw_q.push_back({s_awid, s_awaddr, s_awlen});
            sl_aw++;
         end
         if (s_wvalid && s_wready) begin
            h = saw_q[0];
            a = h[LEN_W +: ADDR_W] + 8 * wbeat;
            check_w(s_wdata, s_wstrb, s_wlast, w_exp[h[Q_W-1] * 4 + wbeat],
                    wbeat == h[LEN_W-1:0]);
            slv_mem[a] = merge(slv_mem.exists(a) ? slv_mem[a] : fill_word(a), s_wdata,
                               s_wstrb);
            wbeat++;
            if (wbeat > h[LEN_W-1:0]) begin
               sb_q.push_back(h[Q_W-1 -: ID_W]);
               void'(saw_q.pop_front());
               wbeat = 0;
               sl_wb++;
            end
         end
         if (s_arvalid && s_arready) begin
            if (!ar_pend[s_arid[3]]) begin
               errors++;
               $display("AR at the slave port with no matching master request at %0t", $time);
            end
            check_aw("AR", s_arid, s_araddr, s_arlen, s_arsize, ar_exp[s_arid[3]]);
            ar_pend[s_arid[3]] = 1'b0;
            sar_q.push_back({s_arid, s_araddr, s_arlen});
            sl_ar++;
         end
         if (s_rvalid && s_rready) begin
            rbeat++;
            if (rbeat > sar_q[0][LEN_W-1:0]) begin
               void'(sar_q.pop_front());
               rbeat = 0;
            end
         end
         if (s_bvalid && s_bready) begin
            void'(sb_q.pop_front());
            sl_b++;
         end
      end
      #1;
      rnd = $random(seed);
      s_awready = rnd[2];
      // W is taken only once its AW has been accepted.
      s_wready  = rnd[1] && (saw_q.size() != 0);
      s_arready = rnd[0];
      s_rvalid = (sar_q.size() != 0);
      if (s_rvalid) begin
         h = sar_q[0];
         a = h[LEN_W +: ADDR_W] + 8 * rbeat;
         s_rid = h[Q_W-1 -: ID_W];
         s_rlast = (rbeat == h[LEN_W-1:0]);
         s_rresp = (a > ADDR_LIMIT) ? DECERR : OKAY;
         s_rdata = (a > ADDR_LIMIT) ? '0 : (slv_mem.exists(a) ? slv_mem[a] : fill_word(a));
      end
      s_bvalid = (sb_q.size() != 0);
      s_bid = s_bvalid ? sb_q[0] : '0;
      s_bresp = OKAY;
   end

   task automatic drain();
      repeat (50 * (DELAY + 1)) @(posedge clk);
      #1;
   endtask

   task automatic report(input string name, input int err_before);
      $display("test %s: %0d errors", name, errors - err_before);
   endtask

   initial begin : watchdog
      #(LIMIT_NS * 1ns);
      $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : main
      int e0;
      clk = 1'b0;
      rstn = 1'b0;
      {awid, awaddr, awlen, awsize, awvalid} = '0;
      {wdata, wstrb, wlast, wvalid} = '0;
      {arid, araddr, arlen, arsize, arvalid} = '0;
      {rready, bready, aw_pend, ar_pend, r_wait, b_wait} = '0;
      {s_awready, s_wready, s_arready, s_rlast, s_rvalid, s_bvalid} = '0;
      {s_rid, s_bid, s_rdata, s_rresp, s_bresp} = '0;
      for (int m = 0; m < 2; m++) begin
         {wr_issued[m], rd_issued[m], b_recv[m], r_recv[m]} = {32'd0, 32'd0, 32'd0, 32'd0};
      end
      repeat (2) @(posedge clk);
      #1 rstn = 1'b1;
      @(posedge clk);
      e0 = errors;
      checks++;
      if ({s_awvalid, s_wvalid, s_arvalid, rvalid, bvalid} !== '0) begin
         errors++;
         $display("[FAIL] %0t: valid output high after reset", $time);
      end
      report("reset_valids", e0);
      #1;
      e0 = errors;
      fork
         run_master(0, N_TXN, 6, 1'b0);
         run_master(1, N_TXN, 6, 1'b0);
      join
      drain();
      report("random_traffic", e0);
      e0 = errors;
      fork
         run_master(0, N_RR, 0, 1'b1);
         run_master(1, N_RR, 0, 1'b1);
      join
      drain();
      if (rr_checks == 0) begin
         errors++;
         $display("No contended AR grant was seen, arbitration was not exercised");
      end
      report("ar_round_robin", e0);
      e0 = errors;
      checks++;
      if (wr_issued[0] + wr_issued[1] != sl_aw || sl_aw != sl_wb || sl_wb != sl_b ||
          sl_b != b_recv[0] + b_recv[1] || rd_issued[0] + rd_issued[1] != sl_ar ||
          sl_ar != r_recv[0] + r_recv[1] || saw_q.size() != 0 || sar_q.size() != 0 ||
          sb_q.size() != 0) begin
         errors++;
         $display("Totals differ: writes %0d/%0d/%0d/%0d/%0d reads %0d/%0d/%0d",
                  wr_issued[0] + wr_issued[1], sl_aw, sl_wb, sl_b, b_recv[0] + b_recv[1],
                  rd_issued[0] + rd_issued[1], sl_ar, r_recv[0] + r_recv[1]);
      end
      report("totals", e0);
      $display("checks %0d, errors %0d, contended AR grants %0d", checks, errors, rr_checks);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
src/axi_mux_pkg.sv
src/axi_bus_if.sv
src/register_slice.sv
src/axi_pipe.sv
src/axi_mux.sv
src/axi_mux_top.sv
test/axi_mux_tb.sv
